// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // address split: tag | index | offset
    localparam int TAG_W     = 20;
    localparam int INDEX_W   = 8;
    localparam int NUM_SETS  = 1 << INDEX_W;
    localparam int OFFSET_W  = 4;
    localparam int BANK_W    = 2;
    localparam int NUM_BANKS = 1 << BANK_W;
    localparam int ADDR_W    = TAG_W + INDEX_W + OFFSET_W;

    localparam int WORD_W = 32;
    localparam int LINE_W = WORD_W * NUM_BANKS;
    localparam int STRB_W = WORD_W / 8;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rw_op_e;

    // bus request size, the cache only issues whole lines
    typedef enum logic [2:0] {
        BUS_BYTE  = 3'b000,
        BUS_HALF  = 3'b001,
        BUS_WORD  = 3'b010,
        BUS_BLOCK = 3'b100
    } bus_type_e;

    typedef enum logic [4:0] {
        S_IDLE    = 5'b00001,
        S_LOOKUP  = 5'b00010,
        S_MISS    = 5'b00100,
        S_REPLACE = 5'b01000,
        S_REFILL  = 5'b10000
    } cache_state_e;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: source/cache_ifs.sv
`timescale 1ns/100ps
`default_nettype none

interface array_if import dcache_pkg::*; ();

    // read index and write index are separate ports on every array
    logic [INDEX_W-1:0]                    index;
    logic [INDEX_W-1:0]                    windex;
    logic [1:0]                            tag_we;
    tag_entry_t                            tag_wdata;
    logic [1:0][NUM_BANKS-1:0][STRB_W-1:0] data_we;
    logic [WORD_W-1:0]                     data_wdata;
    logic                                  dirty_set;
    logic                                  dirty_clr;
    logic                                  dirty_way;

    tag_entry_t [1:0]                      tag_rdata;
    logic [1:0]                            dirty_rdata;
    logic [1:0][LINE_W-1:0]                data_rdata;

    modport ctrl (
        output index, windex, tag_we, tag_wdata, data_we, data_wdata,
        output dirty_set, dirty_clr, dirty_way,
        input  tag_rdata, dirty_rdata, data_rdata
    );

    modport tag (
        input  index, windex, tag_we, tag_wdata, dirty_set, dirty_clr, dirty_way,
        output tag_rdata, dirty_rdata
    );

    modport data (
        input  index, windex, data_we, data_wdata,
        output data_rdata
    );

endinterface

interface wb_if import dcache_pkg::*; ();

    logic               load;
    logic               way;
    logic [BANK_W-1:0]  bank;
    logic [INDEX_W-1:0] index;
    logic [STRB_W-1:0]  strb;
    logic [WORD_W-1:0]  data;

    // held entry, valid while busy
    logic               busy;
    logic               wr_way;
    logic [BANK_W-1:0]  wr_bank;
    logic [INDEX_W-1:0] wr_index;
    logic [STRB_W-1:0]  wr_strb;
    logic [WORD_W-1:0]  wr_data;

    modport ctrl (
        output load, way, bank, index, strb, data,
        input  busy, wr_way, wr_bank, wr_index, wr_strb, wr_data
    );

    modport buffer (
        input  load, way, bank, index, strb, data,
        output busy, wr_way, wr_bank, wr_index, wr_strb, wr_data
    );

endinterface

`default_nettype wire

// File: source/tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module tag_store import dcache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    array_if.tag  arr
);

    tag_entry_t                     tag_mem [2][NUM_SETS];
    tag_entry_t [1:0]               tag_q;
    logic [INDEX_W-1:0]             idx_q;
    logic [1:0][NUM_SETS-1:0]       dirty_bits;

    // valid bits cleared on reset, tags left as they are
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    tag_mem[w][s].valid <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (arr.tag_we[w]) begin
                    tag_mem[w][arr.windex] <= arr.tag_wdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            tag_q[w] <= tag_mem[w][arr.index];
        end
        idx_q <= arr.index;
    end

    assign arr.tag_rdata = tag_q;

    // dirty vectors, one command per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            dirty_bits <= '0;
        end else if (arr.dirty_set) begin
            dirty_bits[arr.dirty_way][arr.windex] <= 1'b1;
        end else if (arr.dirty_clr) begin
            dirty_bits[arr.dirty_way][arr.windex] <= 1'b0;
        end
    end

    // looked up at the index of the last read, so it lines up with tag_q
    assign arr.dirty_rdata[0] = dirty_bits[0][idx_q];
    assign arr.dirty_rdata[1] = dirty_bits[1][idx_q];

endmodule

`default_nettype wire

// File: source/data_store.sv
`timescale 1ns/100ps
`default_nettype none

module data_store import dcache_pkg::*; (
    input  logic  clk,
    array_if.data arr
);

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank

            logic [WORD_W-1:0] mem [NUM_SETS];
            logic [WORD_W-1:0] rd_word;
            logic [WORD_W-1:0] fwd_word;
            logic [STRB_W-1:0] fwd_en;

            always_ff @(posedge clk) begin
                for (int k = 0; k < STRB_W; k++) begin
                    if (arr.data_we[w][b][k]) begin
                        mem[arr.windex][k*8 +: 8] <= arr.data_wdata[k*8 +: 8];
                    end
                end
                rd_word <= mem[arr.index];
            end

            // write-first: a byte written to the line being read shows up
            // in the same read, so a victim read during a buffer write
            // sees the new bytes
            always_ff @(posedge clk) begin
                fwd_en   <= (arr.windex == arr.index) ? arr.data_we[w][b] : '0;
                fwd_word <= arr.data_wdata;
            end

            for (genvar k = 0; k < STRB_W; k++) begin : g_byte
                assign arr.data_rdata[w][b*WORD_W + k*8 +: 8] =
                    fwd_en[k] ? fwd_word[k*8 +: 8] : rd_word[k*8 +: 8];
            end

        end
    end

endmodule

`default_nettype wire

// File: source/write_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module write_buffer import dcache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    wb_if.buffer   wb
);

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b01,
        WB_WRITE = 2'b10
    } wb_state_e;

    wb_state_e          state;
    wb_state_e          state_next;
    logic               hold_way;
    logic [BANK_W-1:0]  hold_bank;
    logic [INDEX_W-1:0] hold_index;
    logic [STRB_W-1:0]  hold_strb;
    logic [WORD_W-1:0]  hold_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= WB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // a new store hit may arrive while the previous one is being written
    always_comb begin
        state_next = wb.load ? WB_WRITE : WB_IDLE;
    end

    always_ff @(posedge clk) begin
        if (wb.load) begin
            hold_way   <= wb.way;
            hold_bank  <= wb.bank;
            hold_index <= wb.index;
            hold_strb  <= wb.strb;
            hold_data  <= wb.data;
        end
    end

    assign wb.busy     = (state == WB_WRITE);
    assign wb.wr_way   = hold_way;
    assign wb.wr_bank  = hold_bank;
    assign wb.wr_index = hold_index;
    assign wb.wr_strb  = hold_strb;
    assign wb.wr_data  = hold_data;

endmodule

`default_nettype wire

// File: source/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl import dcache_pkg::*; #(
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  logic                op,
    input  logic [INDEX_W-1:0]  index,
    input  logic [TAG_W-1:0]    tag,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [STRB_W-1:0]   wstrb,
    input  logic [WORD_W-1:0]   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    output logic                rd_req,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [WORD_W-1:0]   ret_data,
    output logic                wr_req,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [LINE_W-1:0]   wr_data,
    input  logic                wr_rdy,
    array_if.ctrl               arr,
    wb_if.ctrl                  wb
);

    cache_state_e       state;
    cache_state_e       state_next;
    logic               reg_op;
    logic [INDEX_W-1:0] reg_index;
    logic [TAG_W-1:0]   reg_tag;
    logic [BANK_W-1:0]  reg_bank;
    logic [STRB_W-1:0]  reg_wstrb;
    logic [WORD_W-1:0]  reg_wdata;
    logic [BANK_W-1:0]  req_bank;
    logic [1:0]         way_hit;
    logic               cache_hit;
    logic [WORD_W-1:0]  hit_word;
    logic [2:0]         lfsr;
    logic               victim_way;
    tag_entry_t         victim_entry;
    logic               victim_dirty;
    logic [BANK_W-1:0]  refill_cnt;
    logic               refill_beat;
    logic [WORD_W-1:0]  refill_word;
    logic               conflict_wb;
    logic               conflict_store;

    assign req_bank = offset[OFFSET_W-1 -: BANK_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = arr.tag_rdata[w].valid && (arr.tag_rdata[w].tag == reg_tag);
        end
    end
    assign cache_hit = |way_hit;
    assign hit_word  = arr.data_rdata[way_hit[1]][reg_bank*WORD_W +: WORD_W];

    // load into the bank the buffer is writing this cycle
    assign conflict_wb = wb.busy && valid && (op == OP_READ) && (req_bank == wb.wr_bank);
    // load of the very word the store in lookup is about to write
    assign conflict_store = (state == S_LOOKUP) && (reg_op == OP_WRITE) && valid &&
                            (op == OP_READ) &&
                            ({tag, index, req_bank} == {reg_tag, reg_index, reg_bank});

    assign addr_ok = valid && !conflict_wb &&
                     ((state == S_IDLE) ||
                      ((state == S_LOOKUP) && cache_hit && !conflict_store));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            S_IDLE:    state_next = (valid && !conflict_wb) ? S_LOOKUP : S_IDLE;
            S_LOOKUP:  state_next = !cache_hit ? S_MISS : (addr_ok ? S_LOOKUP : S_IDLE);
            S_MISS:    state_next = (wr_rdy || !victim_dirty) ? S_REPLACE : S_MISS;
            S_REPLACE: state_next = rd_rdy ? S_REFILL : S_REPLACE;
            S_REFILL:  state_next = (ret_valid && ret_last) ? S_IDLE : S_REFILL;
            default:   state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            reg_op    <= op;
            reg_index <= index;
            reg_tag   <= tag;
            reg_bank  <= req_bank;
            reg_wstrb <= wstrb;
            reg_wdata <= wdata;
        end
    end

    assign refill_beat = (state == S_REFILL) && ret_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr       <= LFSR_SEED;
            refill_cnt <= '0;
        end else if (refill_beat) begin
            refill_cnt <= refill_cnt + 1'b1;
            if (ret_last) begin
                lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
            end
        end
    end

    assign victim_way   = lfsr[0];
    assign victim_entry = arr.tag_rdata[victim_way];
    assign victim_dirty = victim_entry.valid && arr.dirty_rdata[victim_way];

    // store miss bytes go over the returned word
    always_comb begin
        refill_word = ret_data;
        if ((reg_op == OP_WRITE) && (refill_cnt == reg_bank)) begin
            for (int k = 0; k < STRB_W; k++) begin
                if (reg_wstrb[k]) begin
                    refill_word[k*8 +: 8] = reg_wdata[k*8 +: 8];
                end
            end
        end
    end

    // refill beats win over the buffer, they never overlap in practice
    always_comb begin
        arr.index      = addr_ok ? index : reg_index;
        arr.windex     = reg_index;
        arr.tag_we     = '0;
        arr.tag_wdata  = '{tag: reg_tag, valid: 1'b1};
        arr.data_we    = '0;
        arr.data_wdata = refill_word;
        arr.dirty_set  = 1'b0;
        arr.dirty_clr  = 1'b0;
        arr.dirty_way  = victim_way;
        if (refill_beat) begin
            arr.data_we[victim_way][refill_cnt] = '1;
            if (ret_last) begin
                arr.tag_we[victim_way] = 1'b1;
                arr.dirty_set = (reg_op == OP_WRITE);
                arr.dirty_clr = (reg_op == OP_READ);
            end
        end else if (wb.busy) begin
            arr.windex = wb.wr_index;
            arr.data_we[wb.wr_way][wb.wr_bank] = wb.wr_strb;
            arr.data_wdata = wb.wr_data;
            arr.dirty_set  = 1'b1;
            arr.dirty_way  = wb.wr_way;
        end
    end

    assign wb.load  = (state == S_LOOKUP) && (reg_op == OP_WRITE) && cache_hit;
    assign wb.way   = way_hit[1];
    assign wb.bank  = reg_bank;
    assign wb.index = reg_index;
    assign wb.strb  = reg_wstrb;
    assign wb.data  = reg_wdata;

    assign data_ok = ((state == S_LOOKUP) && (cache_hit || (reg_op == OP_WRITE))) ||
                     (refill_beat && (refill_cnt == reg_bank) && (reg_op == OP_READ));
    assign rdata   = (state == S_REFILL) ? ret_data : hit_word;

    assign rd_req  = (state == S_REPLACE);
    assign rd_addr = {reg_tag, reg_index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state == S_MISS) && victim_dirty;
    assign wr_addr = {victim_entry.tag, reg_index, {OFFSET_W{1'b0}}};
    assign wr_data = arr.data_rdata[victim_way];

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  logic                op,
    input  logic [INDEX_W-1:0]  index,
    input  logic [TAG_W-1:0]    tag,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [STRB_W-1:0]   wstrb,
    input  logic [WORD_W-1:0]   wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    output logic                rd_req,
    output logic [2:0]          rd_type,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [WORD_W-1:0]   ret_data,
    output logic                wr_req,
    output logic [2:0]          wr_type,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [STRB_W-1:0]   wr_wstrb,
    output logic [LINE_W-1:0]   wr_data,
    input  logic                wr_rdy
);

    array_if arr ();
    wb_if    wb ();

    cache_ctrl #(
        .LFSR_SEED (LFSR_SEED)
    ) i_cache_ctrl (
        .clk, .reset,
        .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .arr (arr.ctrl),
        .wb  (wb.ctrl)
    );

    write_buffer i_write_buffer (.clk, .reset, .wb(wb.buffer));
    tag_store    i_tag_store    (.clk, .reset, .arr(arr.tag));
    data_store   i_data_store   (.clk, .arr(arr.data));

    // whole-line transfers only
    assign rd_type  = BUS_BLOCK;
    assign wr_type  = BUS_BLOCK;
    assign wr_wstrb = '1;

endmodule

`default_nettype wire

// File: verif/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model import dcache_pkg::*; #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic              clk,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic              ret_last,
    output logic [WORD_W-1:0] ret_data,
    input  logic              wr_req,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LINE_W-1:0] wr_data,
    output logic              wr_rdy,
    output logic              error
);

    // cpu-visible bytes and the bytes memory really holds
    logic [7:0] golden_mem [logic [ADDR_W-1:0]];
    logic [7:0] backing_mem [logic [ADDR_W-1:0]];
    logic       stored_line [logic [ADDR_W-OFFSET_W-1:0]];
    integer     seed;

    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [WORD_W-1:0] golden_word(input logic [ADDR_W-1:0] a);
        logic [WORD_W-1:0] w;
        logic [ADDR_W-1:0] b;
        for (int k = 0; k < STRB_W; k++) begin
            b = {a[ADDR_W-1:2], 2'b00} + k;
            w[k*8 +: 8] = golden_mem.exists(b) ? golden_mem[b] : fill_byte(b);
        end
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] backing_word(input logic [ADDR_W-1:0] a);
        logic [WORD_W-1:0] w;
        logic [ADDR_W-1:0] b;
        for (int k = 0; k < STRB_W; k++) begin
            b = {a[ADDR_W-1:2], 2'b00} + k;
            w[k*8 +: 8] = backing_mem.exists(b) ? backing_mem[b] : fill_byte(b);
        end
        return w;
    endfunction

    task automatic store_bytes(input logic [ADDR_W-1:0] a, input logic [STRB_W-1:0] strb,
                               input logic [WORD_W-1:0] data);
        for (int k = 0; k < STRB_W; k++) begin
            if (strb[k]) begin
                golden_mem[{a[ADDR_W-1:2], 2'b00} + k] = data[k*8 +: 8];
            end
        end
        stored_line[a[ADDR_W-1:OFFSET_W]] = 1'b1;
    endtask

    task automatic wait_ready_delay(input int max_cycles);
        int n;
        n = {$random(seed)} % (max_cycles + 1);
        @(posedge clk);
        #1;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic serve_write();
        logic [LINE_W-1:0] exp_line;
        logic [ADDR_W-1:0] line;
        wait_ready_delay(3);
        wr_rdy = 1'b1;
        @(negedge clk);
        line = {wr_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        for (int i = 0; i < NUM_BANKS; i++) begin
            exp_line[i*WORD_W +: WORD_W] = golden_word(line + 4 * i);
        end
        assert (stored_line.exists(wr_addr[ADDR_W-1:OFFSET_W])) else begin
            $display("line %h written back although it was never stored to", wr_addr);
            error = 1'b1;
        end
        assert (wr_data == exp_line) else begin
            $display("[FAIL] t=%0t wr_data expected %h got %h", $time, exp_line, wr_data);
            error = 1'b1;
        end
        for (int k = 0; k < LINE_W / 8; k++) begin
            backing_mem[line + k] = wr_data[k*8 +: 8];
        end
        @(posedge clk);
        #1;
        wr_rdy = 1'b0;
    endtask

    task automatic serve_read();
        logic [ADDR_W-1:0] line;
        wait_ready_delay(3);
        rd_rdy = 1'b1;
        @(negedge clk);
        line = {rd_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        @(posedge clk);
        #1;
        rd_rdy = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            // occasional gap between beats
            if ($random(seed) & 1) begin
                ret_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            ret_valid = 1'b1;
            ret_data  = backing_word(line + 4 * i);
            ret_last  = (i == NUM_BANKS - 1);
            @(posedge clk);
            #1;
        end
        ret_valid = 1'b0;
        ret_last  = 1'b0;
    endtask

    initial begin
        seed      = SEED;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        error     = 1'b0;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                serve_write();
            end else if (rd_req) begin
                serve_read();
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_REQ    = NUM_RANDOM + 40;

    typedef struct packed {
        logic              is_load;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] exp;
        logic [31:0]       cyc;
        logic              must_hit;
    } pend_t;

    logic                clk;
    logic                reset;
    logic                valid;
    logic                op;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic [STRB_W-1:0]   wstrb;
    logic [WORD_W-1:0]   wdata;
    logic                addr_ok;
    logic                data_ok;
    logic [WORD_W-1:0]   rdata;
    logic                rd_req;
    logic [2:0]          rd_type;
    logic [ADDR_W-1:0]   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [WORD_W-1:0]   ret_data;
    logic                wr_req;
    logic [2:0]          wr_type;
    logic [ADDR_W-1:0]   wr_addr;
    logic [STRB_W-1:0]   wr_wstrb;
    logic [LINE_W-1:0]   wr_data;
    logic                wr_rdy;
    logic                mem_error;

    integer      seed = 32'ha85e235e;
    pend_t       pending [$];
    int unsigned cycle = 0;
    int unsigned reads_done = 0;
    logic [ADDR_W-OFFSET_W-1:0] last_line;

    dcache_top #(.LFSR_SEED(3'b101)) i_dcache_top (.*);

    mem_model #(.SEED(32'ha85e235e)) i_mem_model (
        .clk, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .error(mem_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        stop_with_failure("value mismatch");
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] t,
                                                    input logic [INDEX_W-1:0] s,
                                                    input logic [BANK_W-1:0] b);
        return {t, s, b, 2'b00};
    endfunction

    // holds valid until addr_ok and leaves it high for a back-to-back request
    task automatic send_request(input logic is_store, input logic [ADDR_W-1:0] addr,
                                input logic [STRB_W-1:0] strb, input logic [WORD_W-1:0] data,
                                input logic must_hit);
        pend_t p;
        logic  done;
        valid  = 1'b1;
        op     = is_store;
        tag    = addr[ADDR_W-1 -: TAG_W];
        index  = addr[OFFSET_W +: INDEX_W];
        offset = addr[OFFSET_W-1:0];
        wstrb  = strb;
        wdata  = data;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = addr_ok;
        end
        if (is_store) begin
            i_mem_model.store_bytes(addr, strb, data);
        end
        p.is_load  = !is_store;
        p.addr     = addr;
        p.exp      = i_mem_model.golden_word(addr);
        p.cyc      = cycle;
        p.must_hit = must_hit;
        pending.push_back(p);
        last_line = addr[ADDR_W-1:OFFSET_W];
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drained();
        valid = 1'b0;
        while (pending.size() != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    // responses come back in request order
    always @(negedge clk) begin
        pend_t p;
        if (data_ok) begin
            assert (pending.size() != 0)
                else stop_with_failure("data_ok with no request outstanding");
            p = pending.pop_front();
            if (p.is_load) begin
                assert (rdata == p.exp) else report_mismatch("rdata", p.exp, rdata);
            end
            if (p.must_hit) begin
                assert (cycle == p.cyc + 1)
                    else report_mismatch("data_ok cycle", p.cyc + 1, cycle);
            end
        end
        if (rd_req) begin
            assert (rd_type == BUS_BLOCK)
                else report_mismatch("rd_type", BUS_BLOCK, rd_type);
        end
        if (wr_req) begin
            assert (wr_type == BUS_BLOCK)
                else report_mismatch("wr_type", BUS_BLOCK, wr_type);
            assert (wr_wstrb == 4'hf)
                else report_mismatch("wr_wstrb", 4'hf, wr_wstrb);
        end
        if (rd_req && rd_rdy) begin
            reads_done++;
            assert (rd_addr == {last_line, 4'h0})
                else report_mismatch("rd_addr", {last_line, 4'h0}, rd_addr);
        end
    end

    always @(posedge mem_error) stop_with_failure("memory model check failed");

    initial begin
        #(NUM_REQ * 200 * CLK_PERIOD);
        stop_with_failure("watchdog expired before all requests completed");
    end

    initial begin
        int          base;
        logic [31:0] r;
        reset = 1'b1;
        valid = 1'b0;
        op    = 1'b0;
        index = '0;
        tag   = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!rd_req && !wr_req && !data_ok)
                else stop_with_failure("bus request or data_ok active after reset");
        end
        @(posedge clk);
        #1;

        // load misses and then hits on the same words
        for (int i = 0; i < 4; i++) begin
            send_request(0, make_addr(20'h10, 8'h05, i[1:0]), 0, 0, 0);
        end
        wait_drained();
        base = reads_done;
        for (int i = 0; i < 4; i++) begin
            send_request(0, make_addr(20'h10, 8'h05, i[1:0]), 0, 0, 1);
        end
        wait_drained();
        assert (reads_done == base) else stop_with_failure("refill issued for a cached line");

        // store hit and one idle cycle before the load back
        send_request(1, make_addr(20'h10, 8'h05, 2'd1), 4'b0101, $random(seed), 0);
        valid = 1'b0;
        @(posedge clk);
        #1;
        send_request(0, make_addr(20'h10, 8'h05, 2'd1), 0, 0, 0);
        wait_drained();

        // store miss merges into the refilled word
        send_request(1, make_addr(20'h22, 8'h09, 2'd2), 4'b1110, $random(seed), 0);
        wait_drained();
        send_request(0, make_addr(20'h22, 8'h09, 2'd2), 0, 0, 0);
        wait_drained();

        // four tags in one set force dirty evictions
        for (int p = 0; p < 2; p++) begin
            for (int t = 0; t < 4; t++) begin
                send_request(1, make_addr(20'h300 + t, 8'h20, p[1:0]), 4'hf, $random(seed), 0);
            end
            wait_drained();
            for (int t = 0; t < 4; t++) begin
                send_request(0, make_addr(20'h300 + t, 8'h20, p[1:0]), 0, 0, 0);
            end
            wait_drained();
        end

        // random mix over four sets
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            send_request(r[0], make_addr(20'h100 + r[4:3], 8'h40 + r[2:1], r[6:5]),
                         r[10:7], $random(seed), 0);
            if (r[11]) begin
                valid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        wait_drained();
        repeat (4) @(posedge clk);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/dcache_pkg.sv
source/cache_ifs.sv
source/tag_store.sv
source/data_store.sv
source/write_buffer.sv
source/cache_ctrl.sv
source/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dcache \
    -f tb.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run FAILED"
    exit 1
fi
echo "run passed"
exit 0
